// File: gpuIssue.f
+incdir+.
gpuIssuePkg.sv
instrBufferWarp.sv
warpScoreboard.sv
issueArbiter.sv
gpuIssue.sv
gpuIssue_checker.sv
gpuIssueTb.sv

// File: gpuIssue.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module gpuIssue import gpuIssuePkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`GPU_NUM_WARPS-1:0] decValid,
    input  decodedInstr_t             decInstr [`GPU_NUM_WARPS],
    input  threadMask_t               activeMask [`GPU_NUM_WARPS],
    input  logic [`GPU_NUM_WARPS-1:0] dropInstr,
    input  logic                      fullOc,
    input  memFeedback_t              memFb,
    input  logic                      wbValid,
    input  warpId_t                   wbWarp,
    input  scbId_t                    wbScbId,
    output logic                      issueValid,
    output issueInfo_t                issueInfo,
    output logic [`GPU_NUM_WARPS-1:0] reqFetch,
    output logic [`GPU_NUM_WARPS-1:0] warpExit
);

    logic [`GPU_NUM_WARPS-1:0] issueReq;
    logic [`GPU_NUM_WARPS-1:0] issueGrant;
    issueInfo_t warpInfo [`GPU_NUM_WARPS];

    //////////////////////////////
    // per-warp buffer and scoreboard
    //////////////////////////////
    for (genvar w = 0; w < `GPU_NUM_WARPS; w++) begin : gWarp
        decodedInstr_t headInstr;
        scbId_t        scbId;
        scbId_t        replayScbId;
        logic          scbDependent;
        logic          scbFull;
        logic          scbEmpty;
        logic          scbAlloc;
        logic          replayDone;
        logic          fbHit;
        logic          wbHit;

        // feedback and writeback name their warp
        assign fbHit = (memFb.warpId == warpId_t'(w));
        assign wbHit = wbValid & (wbWarp == warpId_t'(w));

        instrBufferWarp #(.warpIndex(warpId_t'(w))) ibuf (
            .clk(clk), .rst(rst),
            .decValid(decValid[w]), .decInstr(decInstr[w]),
            .activeMask(activeMask[w]), .dropInstr(dropInstr[w]),
            .issueGrant(issueGrant[w]), .scbDependent(scbDependent),
            .scbFull(scbFull), .scbEmpty(scbEmpty), .scbId(scbId),
            .fbPos(memFb.posValid & fbHit), .fbZero(memFb.zeroValid & fbHit),
            .fbMask(memFb.doneMask), .reqFetch(reqFetch[w]),
            .issueReq(issueReq[w]), .issueInfo(warpInfo[w]),
            .headInstr(headInstr), .scbAlloc(scbAlloc), .replayDone(replayDone),
            .replayScbId(replayScbId), .warpExit(warpExit[w])
        );

        warpScoreboard scb (
            .clk(clk), .rst(rst), .srcInstr(headInstr), .alloc(scbAlloc),
            .wbValid(wbHit), .wbScbId(wbScbId),
            .replayDone(replayDone), .replayScbId(replayScbId),
            .scbId(scbId), .dependent(scbDependent), .full(scbFull), .empty(scbEmpty)
        );
    end

    issueArbiter arb (
        .clk(clk), .rst(rst), .req(issueReq), .fullOc(fullOc), .grant(issueGrant)
    );

    // one-hot grant selects the payload
    always_comb begin
        issueInfo = '0;
        for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
            if (issueGrant[w]) begin
                issueInfo = warpInfo[w];
            end
        end
    end

    assign issueValid = |issueGrant;

endmodule

`default_nettype wire

// File: gpuIssuePkg.sv
`default_nettype none

`include "gpuIssue_config.svh"

package gpuIssuePkg;

    // derived widths
    localparam int warpIdW = (`GPU_NUM_WARPS > 1) ? $clog2(`GPU_NUM_WARPS) : 1;
    localparam int scbIdW  = $clog2(`GPU_SCB_DEPTH);
    // buffer pointers carry one extra wrap bit
    localparam int ibPtrW  = $clog2(`GPU_IB_DEPTH) + 1;

    typedef logic [4:0]                   regId_t;
    typedef logic [`GPU_NUM_THREADS-1:0]  threadMask_t;
    typedef logic [warpIdW-1:0]           warpId_t;
    typedef logic [scbIdW-1:0]            scbId_t;
    typedef logic [3:0]                   aluOp_t;
    typedef logic [ibPtrW-1:0]            ibPtr_t;

    //////////////////////////////
    // decode to issue payload
    //////////////////////////////
    typedef struct packed {
        logic [31:0] instrWord;
        regId_t      src1;
        logic        src1Valid;
        regId_t      src2;
        logic        src2Valid;
        regId_t      dst;
        aluOp_t      aluOp;
        logic [15:0] imm;
        logic        immValid;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        isShared;
        logic        isExit;
    } decodedInstr_t;

    // what goes to the operand collector
    typedef struct packed {
        decodedInstr_t instr;
        threadMask_t   mask;
        warpId_t       warpId;
        scbId_t        scbId;
        logic          isReplay;
    } issueInfo_t;

    // memory stage feedback for the oldest outstanding access
    typedef struct packed {
        logic        posValid;
        logic        zeroValid;
        warpId_t     warpId;
        threadMask_t doneMask;
    } memFeedback_t;

endpackage

`default_nettype wire

// File: gpuIssueTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module gpuIssueTb import gpuIssuePkg::*; ();

    localparam int nWarps = `GPU_NUM_WARPS;
    localparam int nSlots = `GPU_SCB_DEPTH;
    localparam int instrPerWarp = 60;
    // generous budget per instruction for stalls and replays
    localparam int timeoutCycles = instrPerWarp * nWarps * 32 + 160;

    logic              clk;
    logic              rst;
    logic [nWarps-1:0] decValid;
    decodedInstr_t     decInstr [nWarps];
    threadMask_t       activeMask [nWarps];
    logic [nWarps-1:0] dropInstr;
    logic              fullOc;
    memFeedback_t      memFb;
    logic              wbValid;
    warpId_t           wbWarp;
    scbId_t            wbScbId;
    logic              issueValid;
    issueInfo_t        issueInfo;
    logic [nWarps-1:0] reqFetch;
    logic [nWarps-1:0] warpExit;

    // reference model state
    decodedInstr_t     expInstr [nWarps][$];
    threadMask_t       expMask [nWarps][$];
    logic [nSlots-1:0] slotBusy [nWarps];
    logic [nSlots-1:0] slotWr [nWarps];
    regId_t            slotDst [nWarps][nSlots];
    logic              memOut [nWarps];
    logic              memAwait [nWarps];
    threadMask_t       memMask [nWarps];
    scbId_t            memScb [nWarps];
    logic [31:0]       memWord [nWarps];
    int                held [nWarps];
    // retired entries still queued behind an outstanding access
    int                behind [nWarps];
    int                driven [nWarps];
    logic [nWarps-1:0] canWrite;
    int                wbWarpQ [$];
    int                wbSlotQ [$];
    int                cycles;

    gpuIssue dut0 (
        .clk(clk), .rst(rst), .decValid(decValid), .decInstr(decInstr),
        .activeMask(activeMask), .dropInstr(dropInstr), .fullOc(fullOc),
        .memFb(memFb), .wbValid(wbValid), .wbWarp(wbWarp), .wbScbId(wbScbId),
        .issueValid(issueValid), .issueInfo(issueInfo), .reqFetch(reqFetch),
        .warpExit(warpExit)
    );

    always #4 clk = ~clk;

    task automatic reportMismatch(input string test, input logic [95:0] expVal,
                                  input logic [95:0] actVal);
        $display("Mismatch in %s: expected %0h, actual %0h", test, expVal, actVal);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stopOnError(input string what);
        $display("Error: %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // any busy slot that will write register r
    function automatic logic regBusy(input int w, input regId_t r);
        for (int s = 0; s < nSlots; s++) begin
            if (slotBusy[w][s] && slotWr[w][s] && slotDst[w][s] == r) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int lowestFree(input int w);
        for (int s = 0; s < nSlots; s++) begin
            if (!slotBusy[w][s]) begin
                return s;
            end
        end
        return 0;
    endfunction

    // word carries drop flag, warp and sequence number
    function automatic decodedInstr_t makeInstr(input int w, input int seq, input logic drop);
        decodedInstr_t d;
        int kind;
        d = '0;
        kind = $urandom_range(0, 9);
        d.instrWord = {drop, 7'd0, 8'(w), 16'(seq)};
        d.src1      = regId_t'($urandom_range(0, 7));
        d.src1Valid = $urandom_range(0, 1);
        d.src2      = regId_t'($urandom_range(0, 7));
        d.src2Valid = $urandom_range(0, 1);
        d.dst       = regId_t'($urandom_range(0, 7));
        d.aluOp     = aluOp_t'($urandom);
        d.imm       = 16'($urandom);
        d.immValid  = $urandom_range(0, 1);
        if (kind == 0) begin
            d.isExit    = 1'b1;
            d.src1Valid = 1'b0;
            d.src2Valid = 1'b0;
        end else if (kind <= 2) begin
            d.memRead  = 1'b1;
            d.regWrite = 1'b1;
            d.isShared = $urandom_range(0, 1);
        end else if (kind == 3) begin
            d.memWrite = 1'b1;
        end else begin
            d.regWrite = (kind != 4);
        end
        return d;
    endfunction

    function automatic logic allDone();
        for (int w = 0; w < nWarps; w++) begin
            if (driven[w] < instrPerWarp || expInstr[w].size() != 0 || memOut[w] ||
                slotBusy[w] != '0) begin
                return 1'b0;
            end
        end
        return (wbWarpQ.size() == 0);
    endfunction

    //////////////////////////////
    // stimulus on falling edges
    //////////////////////////////
    always @(negedge clk) begin : driveBlock
        logic drop;
        logic sent;
        fullOc = ($urandom_range(0, 3) == 0);
        for (int w = 0; w < nWarps; w++) begin
            decValid[w]  = 1'b0;
            dropInstr[w] = 1'b0;
            if (canWrite[w] && driven[w] < instrPerWarp && $urandom_range(0, 3) != 0) begin
                drop          = ($urandom_range(0, 7) == 0);
                decInstr[w]   = makeInstr(w, driven[w], drop);
                activeMask[w] = threadMask_t'($urandom) | threadMask_t'(1);
                dropInstr[w]  = drop;
                decValid[w]   = 1'b1;
                driven[w]++;
            end
        end
        wbValid = 1'b0;
        if (wbWarpQ.size() > 0 && $urandom_range(0, 1) == 1) begin
            wbValid = 1'b1;
            wbWarp  = warpId_t'(wbWarpQ.pop_front());
            wbScbId = scbId_t'(wbSlotQ.pop_front());
        end
        // one feedback per cycle, for a memory op not waiting on replay
        memFb = '0;
        sent  = 1'b0;
        for (int w = 0; w < nWarps; w++) begin
            if (!sent && memOut[w] && !memAwait[w] && $urandom_range(0, 2) == 0) begin
                sent         = 1'b1;
                memFb.warpId = warpId_t'(w);
                if ($urandom_range(0, 3) == 0) begin
                    memFb.zeroValid = 1'b1;
                end else begin
                    memFb.posValid = 1'b1;
                    memFb.doneMask = threadMask_t'($urandom) & memMask[w];
                    if ($urandom_range(0, 2) == 0) begin
                        memFb.doneMask = memMask[w];
                    end
                end
            end
        end
    end

    //////////////////////////////
    // checks at the rising edge
    //////////////////////////////
    always @(posedge clk) begin : sampleBlock
        int w;
        int s;
        int fill;
        logic isMem;
        decodedInstr_t head;
        if (rst) begin
            cycles++;
            if (cycles >= timeoutCycles) begin
                stopOnError("timeout, instructions did not drain");
            end
            if (dut0.chk0.failCount != 0) begin
                stopOnError("a checker assertion failed");
            end
            for (int i = 0; i < nWarps; i++) begin
                // ring occupancy from the oldest outstanding access to the tail
                fill = held[i] + behind[i] + ((decValid[i] && !dropInstr[i]) ? 1 : 0);
                assert (reqFetch[i] == (fill < `GPU_IB_DEPTH))
                    else reportMismatch("fetch flow", 32'(fill < `GPU_IB_DEPTH),
                                        32'(reqFetch[i]));
                if (warpExit[i]) begin
                    if (expInstr[i].size() == 0 || !expInstr[i][0].isExit) begin
                        stopOnError("warp exit without an exit at the head");
                    end
                    if (slotBusy[i] != '0) begin
                        stopOnError("warp exit while its scoreboard is busy");
                    end
                    void'(expInstr[i].pop_front());
                    void'(expMask[i].pop_front());
                    held[i]--;
                end
            end
            if (issueValid) begin
                w = int'(issueInfo.warpId);
                if (issueInfo.isReplay) begin
                    if (!memAwait[w]) begin
                        stopOnError("replay issued without a pending feedback");
                    end
                    assert (issueInfo.instr.instrWord == memWord[w])
                        else reportMismatch("replay word", memWord[w], issueInfo.instr.instrWord);
                    assert (issueInfo.mask == memMask[w])
                        else reportMismatch("replay mask", 32'(memMask[w]), 32'(issueInfo.mask));
                    assert (issueInfo.scbId == memScb[w])
                        else reportMismatch("replay scbId", 32'(memScb[w]), 32'(issueInfo.scbId));
                    memAwait[w] = 1'b0;
                end else begin
                    if (expInstr[w].size() == 0) begin
                        stopOnError("issue from a warp with nothing queued");
                    end
                    head = expInstr[w][0];
                    assert (issueInfo.instr == head)
                        else reportMismatch("in-order issue", head, issueInfo.instr);
                    assert (issueInfo.mask == expMask[w][0])
                        else reportMismatch("issue mask", 32'(expMask[w][0]),
                                            32'(issueInfo.mask));
                    if (head.isExit) begin
                        stopOnError("exit instruction was issued");
                    end
                    if ((head.src1Valid && regBusy(w, head.src1)) ||
                        (head.src2Valid && regBusy(w, head.src2)) ||
                        (head.regWrite && regBusy(w, head.dst))) begin
                        stopOnError("instruction issued over a busy register");
                    end
                    isMem = head.memRead | head.memWrite;
                    s = lowestFree(w);
                    if (head.regWrite || isMem) begin
                        assert (issueInfo.scbId == scbId_t'(s))
                            else reportMismatch("scoreboard slot", 32'(s), 32'(issueInfo.scbId));
                        slotBusy[w][s] = 1'b1;
                        slotWr[w][s]   = head.regWrite;
                        slotDst[w][s]  = head.dst;
                        if (!isMem) begin
                            wbWarpQ.push_back(w);
                            wbSlotQ.push_back(s);
                        end
                    end
                    if (isMem) begin
                        if (memOut[w]) begin
                            stopOnError("second memory access issued while one is pending");
                        end
                        memOut[w]   = 1'b1;
                        memAwait[w] = 1'b0;
                        memMask[w]  = issueInfo.mask;
                        memScb[w]   = scbId_t'(s);
                        memWord[w]  = head.instrWord;
                    end else begin
                        held[w]--;
                        if (memOut[w]) begin
                            behind[w]++;
                        end
                    end
                    void'(expInstr[w].pop_front());
                    void'(expMask[w].pop_front());
                end
            end
            // frees take effect after this edge
            if (wbValid) begin
                slotBusy[int'(wbWarp)][int'(wbScbId)] = 1'b0;
            end
            if (memFb.posValid || memFb.zeroValid) begin
                w = int'(memFb.warpId);
                if (memFb.posValid) begin
                    memMask[w] = memMask[w] & ~memFb.doneMask;
                end
                if (memFb.posValid && memMask[w] == '0) begin
                    memOut[w] = 1'b0;
                    slotBusy[w][memScb[w]] = 1'b0;
                    held[w]--;
                    behind[w] = 0;
                end else begin
                    memAwait[w] = 1'b1;
                end
            end
            for (int i = 0; i < nWarps; i++) begin
                if (decValid[i] && !dropInstr[i]) begin
                    expInstr[i].push_back(decInstr[i]);
                    expMask[i].push_back(activeMask[i]);
                    held[i]++;
                end
            end
            canWrite = reqFetch;
        end
    end

    initial begin
        void'($urandom(32'h8cfd));
        clk       = 1'b0;
        rst       = 1'b0;
        decValid  = '0;
        dropInstr = '0;
        fullOc    = 1'b0;
        memFb     = '0;
        wbValid   = 1'b0;
        wbWarp    = '0;
        wbScbId   = '0;
        canWrite  = '0;
        cycles    = 0;
        for (int w = 0; w < nWarps; w++) begin
            decInstr[w]   = '0;
            activeMask[w] = '0;
            slotBusy[w]   = '0;
            slotWr[w]     = '0;
            memOut[w]     = 1'b0;
            memAwait[w]   = 1'b0;
            memMask[w]    = '0;
            memScb[w]     = '0;
            memWord[w]    = '0;
            held[w]       = 0;
            behind[w]     = 0;
            driven[w]     = 0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b1;
        while (!allDone()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (dut0.chk0.failCount == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: gpuIssue_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module gpuIssue_checker import gpuIssuePkg::*; (
    input logic                      clk,
    input logic                      rst,
    input logic                      fullOc,
    input logic                      issueValid,
    input issueInfo_t                issueInfo,
    input logic [`GPU_NUM_WARPS-1:0] reqFetch,
    input logic [`GPU_NUM_WARPS-1:0] warpExit
);

    int failCount = 0;

    //////////////////////////////
    // port level rules
    //////////////////////////////

    // operand collector back-pressure
    noIssueWhenFull: assert property (@(posedge clk) disable iff (!rst)
        fullOc |-> !issueValid)
        else begin
            failCount++;
            $error("issue while the operand collector is full");
        end

    noIssueOnExit: assert property (@(posedge clk) disable iff (!rst)
        issueValid |-> !warpExit[issueInfo.warpId])
        else begin
            failCount++;
            $error("warp issued in its exit cycle");
        end

    // first cycle out of reset
    resetState: assert property (@(posedge clk)
        $rose(rst) |-> (&reqFetch && !issueValid && warpExit == '0))
        else begin
            failCount++;
            $error("outputs not in reset state after reset");
        end

endmodule

bind gpuIssue gpuIssue_checker chk0 (
    .clk(clk),
    .rst(rst),
    .fullOc(fullOc),
    .issueValid(issueValid),
    .issueInfo(issueInfo),
    .reqFetch(reqFetch),
    .warpExit(warpExit)
);

`default_nettype wire

// File: gpuIssue_config.svh
`ifndef GPU_ISSUE_CONFIG_SVH
`define GPU_ISSUE_CONFIG_SVH

//////////////////////////////
// issue stage sizing
//////////////////////////////

// warps sharing the operand collector port
`define GPU_NUM_WARPS 2

// threads per warp, one mask bit each
`define GPU_NUM_THREADS 8

// instruction buffer entries per warp
`define GPU_IB_DEPTH 4

// in-flight destination slots per warp
`define GPU_SCB_DEPTH 4

`endif

// File: instrBufferWarp.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module instrBufferWarp import gpuIssuePkg::*; #(
    parameter warpId_t warpIndex = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          decValid,
    input  decodedInstr_t decInstr,
    input  threadMask_t   activeMask,
    input  logic          dropInstr,
    input  logic          issueGrant,
    input  logic          scbDependent,
    input  logic          scbFull,
    input  logic          scbEmpty,
    input  scbId_t        scbId,
    input  logic          fbPos,
    input  logic          fbZero,
    input  threadMask_t   fbMask,
    output logic          reqFetch,
    output logic          issueReq,
    output issueInfo_t    issueInfo,
    output decodedInstr_t headInstr,
    output logic          scbAlloc,
    output logic          replayDone,
    output scbId_t        replayScbId,
    output logic          warpExit
);

    localparam int idxW = ibPtrW - 1;

    // entry storage
    decodedInstr_t entryInstr [`GPU_IB_DEPTH];
    threadMask_t   entryMask  [`GPU_IB_DEPTH];
    scbId_t        entryScb   [`GPU_IB_DEPTH];
    logic [`GPU_IB_DEPTH-1:0] entryValid;
    logic [`GPU_IB_DEPTH-1:0] entryReplay;
    logic [`GPU_IB_DEPTH-1:0] validNext;
    logic [`GPU_IB_DEPTH-1:0] replayNext;

    // write, issue and replay pointers
    ibPtr_t wp;
    ibPtr_t irp;
    ibPtr_t rpp;
    ibPtr_t irpNext;
    ibPtr_t rppNext;
    logic [idxW-1:0] wrIdx;
    logic [idxW-1:0] headIdx;
    logic [idxW-1:0] replayIdx;
    logic [ibPtrW:0] fillCount;

    logic        writeEn;
    logic        bufFull;
    logic        headValid;
    logic        headIsMem;
    logic        replayActive;
    logic        replayReq;
    logic        replaySet;
    logic        firstReq;
    logic        firstGrant;
    logic        replayGrant;
    logic        exitRetire;
    threadMask_t maskNext;

    assign wrIdx     = wp[idxW-1:0];
    assign headIdx   = irp[idxW-1:0];
    assign replayIdx = rpp[idxW-1:0];

    //////////////////////////////
    // decode side
    //////////////////////////////
    assign bufFull   = (ibPtr_t'(wp - rpp) == ibPtr_t'(`GPU_IB_DEPTH));
    assign writeEn   = decValid & ~dropInstr & ~bufFull;
    // occupancy including the write happening now
    assign fillCount = {1'b0, ibPtr_t'(wp - rpp)} + {{ibPtrW{1'b0}}, writeEn};
    assign reqFetch  = (fillCount < `GPU_IB_DEPTH);

    //////////////////////////////
    // issue requests
    //////////////////////////////
    assign headInstr = entryInstr[headIdx];
    assign headValid = (irp != wp);
    assign headIsMem = headInstr.memRead | headInstr.memWrite;

    // a memory access waiting on feedback sits behind the issue pointer
    assign replayActive = (rpp != irp) & entryValid[replayIdx];
    assign replayReq    = replayActive & entryReplay[replayIdx];

    // only one memory access outstanding per warp
    assign firstReq = headValid & ~headInstr.isExit & ~scbDependent & ~scbFull &
                      ~(headIsMem & replayActive) & ~replayReq;

    assign issueReq    = replayReq | firstReq;
    assign replayGrant = issueGrant & replayReq;
    assign firstGrant  = issueGrant & firstReq;
    assign scbAlloc    = firstGrant;

    // exit leaves once nothing of this warp is in flight
    assign exitRetire = headValid & headInstr.isExit & scbEmpty;
    assign warpExit   = exitRetire;

    always_comb begin
        issueInfo.instr    = replayReq ? entryInstr[replayIdx] : headInstr;
        issueInfo.mask     = replayReq ? entryMask[replayIdx] : entryMask[headIdx];
        issueInfo.warpId   = warpIndex;
        issueInfo.scbId    = replayReq ? entryScb[replayIdx] : scbId;
        issueInfo.isReplay = replayReq;
    end

    //////////////////////////////
    // memory feedback
    //////////////////////////////
    assign maskNext    = fbPos ? (entryMask[replayIdx] & ~fbMask) : entryMask[replayIdx];
    assign replayDone  = replayActive & fbPos & (maskNext == '0);
    assign replaySet   = replayActive & (fbZero | (fbPos & (maskNext != '0)));
    assign replayScbId = entryScb[replayIdx];

    always_comb begin
        validNext = entryValid;
        // non-memory entries leave on their grant
        if (firstGrant && !headIsMem) begin
            validNext[headIdx] = 1'b0;
        end
        if (exitRetire) begin
            validNext[headIdx] = 1'b0;
        end
        if (replayDone) begin
            validNext[replayIdx] = 1'b0;
        end
        if (writeEn) begin
            validNext[wrIdx] = 1'b1;
        end
    end

    always_comb begin
        replayNext = entryReplay;
        if (replayGrant) begin
            replayNext[replayIdx] = 1'b0;
        end
        if (replaySet) begin
            replayNext[replayIdx] = 1'b1;
        end
        if (writeEn) begin
            replayNext[wrIdx] = 1'b0;
        end
    end

    assign irpNext = irp + ibPtr_t'(firstGrant | exitRetire);
    // replay pointer skips retired entries up to the issue pointer
    assign rppNext = validNext[replayIdx] ? rpp : irpNext;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wp          <= '0;
            irp         <= '0;
            rpp         <= '0;
            entryValid  <= '0;
            entryReplay <= '0;
        end else begin
            wp          <= wp + ibPtr_t'(writeEn);
            irp         <= irpNext;
            rpp         <= rppNext;
            entryValid  <= validNext;
            entryReplay <= replayNext;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            entryInstr[wrIdx] <= decInstr;
            entryMask[wrIdx]  <= activeMask;
        end
        // private mask shrinks as threads complete
        if (replayActive && fbPos) begin
            entryMask[replayIdx] <= maskNext;
        end
        if (firstGrant) begin
            entryScb[headIdx] <= scbId;
        end
    end

endmodule

`default_nettype wire

// File: issueArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module issueArbiter import gpuIssuePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`GPU_NUM_WARPS-1:0] req,
    input  logic                     fullOc,
    output logic [`GPU_NUM_WARPS-1:0] grant
);

    warpId_t rrPtr;
    warpId_t grantIdx;

    // scan from the priority pointer, nearest request wins
    always_comb begin
        int idx;
        grant    = '0;
        grantIdx = rrPtr;
        for (int i = `GPU_NUM_WARPS - 1; i >= 0; i--) begin
            idx = int'(rrPtr) + i;
            if (idx >= `GPU_NUM_WARPS) begin
                idx = idx - `GPU_NUM_WARPS;
            end
            if (req[idx] && !fullOc) begin
                grant      = '0;
                grant[idx] = 1'b1;
                grantIdx   = warpId_t'(idx);
            end
        end
    end

    // priority moves past the granted warp
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rrPtr <= '0;
        end else if (|grant) begin
            if (grantIdx == warpId_t'(`GPU_NUM_WARPS - 1)) begin
                rrPtr <= '0;
            end else begin
                rrPtr <= grantIdx + warpId_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: warpScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpuIssue_config.svh"

module warpScoreboard import gpuIssuePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  decodedInstr_t srcInstr,
    input  logic          alloc,
    input  logic          wbValid,
    input  scbId_t        wbScbId,
    input  logic          replayDone,
    input  scbId_t        replayScbId,
    output scbId_t        scbId,
    output logic          dependent,
    output logic          full,
    output logic          empty
);

    logic [`GPU_SCB_DEPTH-1:0] busy;
    logic [`GPU_SCB_DEPTH-1:0] writesReg;
    logic [`GPU_SCB_DEPTH-1:0] hit;
    regId_t entryDst [`GPU_SCB_DEPTH];
    logic   needsEntry;

    // stores and loads need a slot even without a register write
    assign needsEntry = srcInstr.regWrite | srcInstr.memRead | srcInstr.memWrite;

    assign full  = &busy;
    assign empty = ~|busy;

    // lowest free slot
    always_comb begin
        scbId = '0;
        for (int i = `GPU_SCB_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                scbId = scbId_t'(i);
            end
        end
    end

    //////////////////////////////
    // RAW and WAW check
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < `GPU_SCB_DEPTH; i++) begin
            hit[i] = busy[i] & writesReg[i] &
                     ((srcInstr.src1Valid & (entryDst[i] == srcInstr.src1)) |
                      (srcInstr.src2Valid & (entryDst[i] == srcInstr.src2)) |
                      (srcInstr.regWrite  & (entryDst[i] == srcInstr.dst)));
        end
    end

    assign dependent = |hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            if (alloc && needsEntry) begin
                busy[scbId] <= 1'b1;
            end
            // writeback for ALU ops, replayDone for memory ops
            if (wbValid) begin
                busy[wbScbId] <= 1'b0;
            end
            if (replayDone) begin
                busy[replayScbId] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && needsEntry) begin
            entryDst[scbId]  <= srcInstr.dst;
            writesReg[scbId] <= srcInstr.regWrite;
        end
    end

endmodule

`default_nettype wire
